// File: decode_stage.sv
`timescale 1ns/1ps

module decode_stage import isa_pkg::*, pipe_pkg::*; (
    input  logic     aclk,
    input  logic     rst,
    input  logic     head_valid,
    input  word_t    head_instr,
    input  word_t    head_pc,
    input  logic     ex_busy,
    input  logic     ex_fwd_valid,
    input  reg_idx_t ex_fwd_dst,
    input  word_t    ex_fwd_data,
    input  logic     wr_en,
    input  reg_idx_t wr_idx,
    input  word_t    wr_data,
    input  word_t    rd_data_a,
    input  word_t    rd_data_b,
    output logic     pop,
    output reg_idx_t rd_idx_a,
    output reg_idx_t rd_idx_b,
    output logic     d_valid,
    output alu_op_e  d_op,
    output word_t    d_a,
    output word_t    d_b,
    output reg_idx_t d_dst,
    output logic     d_wr,
    output word_t    d_pc
);

    opcode_e  opcode;
    funct_e   funct;
    reg_idx_t rs;
    reg_idx_t rt;
    reg_idx_t rd;
    imm_t     imm;
    alu_op_e  op;
    reg_idx_t dst;
    word_t    imm_ext;
    logic     use_imm;
    logic     known;

    assign opcode = opcode_e'(head_instr[31:26]);
    assign funct  = funct_e'(head_instr[5:0]);
    assign rs     = head_instr[25:21];
    assign rt     = head_instr[20:16];
    assign rd     = head_instr[15:11];
    assign imm    = head_instr[15:0];

    assign rd_idx_a = rs;
    assign rd_idx_b = rt;
    assign pop      = head_valid && !ex_busy;

    always_comb begin
        op      = ALU_ADD;
        dst     = rd;
        imm_ext = {16'h0, imm};     // zero extend unless ADDIU
        use_imm = 1'b0;
        known   = 1'b0;
        case (opcode)
            OP_SPECIAL: begin
                known = 1'b1;
                case (funct)
                    FN_ADDU: op = ALU_ADD;
                    FN_SUBU: op = ALU_SUB;
                    FN_AND:  op = ALU_AND;
                    FN_OR:   op = ALU_OR;
                    FN_XOR:  op = ALU_XOR;
                    FN_SLT:  op = ALU_SLT;
                    default: known = 1'b0;
                endcase
            end
            OP_SPECIAL2: begin
                op    = ALU_MUL;
                known = (funct == FN_MUL);
            end
            OP_ADDIU: begin
                known   = 1'b1;
                dst     = rt;
                use_imm = 1'b1;
                imm_ext = {{16{imm[15]}}, imm};
            end
            OP_ORI: begin
                op      = ALU_OR;
                known   = 1'b1;
                dst     = rt;
                use_imm = 1'b1;
            end
            OP_LUI: begin
                op      = ALU_LUI;
                known   = 1'b1;
                dst     = rt;
                use_imm = 1'b1;
            end
            default: known = 1'b0;
        endcase
    end

    // newest value wins: execute, then write-back, then the file
    function automatic word_t operand(reg_idx_t idx, word_t rf_val);
        word_t val;
        val = rf_val;
        if (ex_fwd_valid && ex_fwd_dst == idx) begin
            val = ex_fwd_data;
        end else if (wr_en && wr_idx == idx) begin
            val = wr_data;
        end
        return val;
    endfunction

    always_ff @(posedge aclk) begin
        if (rst) begin
            d_valid <= 1'b0;
            d_wr    <= 1'b0;
        end else if (!ex_busy) begin
            d_valid <= head_valid;      // bubble when the queue is empty
            d_wr    <= head_valid && known && dst != '0;
        end
    end

    always_ff @(posedge aclk) begin
        if (pop) begin
            d_op  <= op;
            d_a   <= operand(rs, rd_data_a);
            d_b   <= use_imm ? imm_ext : operand(rt, rd_data_b);
            d_dst <= dst;
            d_pc  <= head_pc;
        end
    end

endmodule

// File: execute_stage.sv
`timescale 1ns/1ps

module execute_stage import isa_pkg::*, pipe_pkg::*; #(
    parameter int MUL_STEP_BITS = 2
) (
    input  logic     aclk,
    input  logic     rst,
    input  logic     d_valid,
    input  alu_op_e  d_op,
    input  word_t    d_a,
    input  word_t    d_b,
    input  reg_idx_t d_dst,
    input  logic     d_wr,
    input  word_t    d_pc,
    output logic     ex_busy,
    output logic     ex_fwd_valid,
    output reg_idx_t ex_fwd_dst,
    output word_t    ex_fwd_data,
    output logic     x_valid,
    output logic     x_wr,
    output reg_idx_t x_dst,
    output word_t    x_data,
    output word_t    x_pc
);

    localparam int STEPS = 32 / MUL_STEP_BITS;
    localparam int CNT_W = $clog2(STEPS);

    mul_state_e       mul_state;
    logic [CNT_W-1:0] mul_cnt;
    word_t            acc;
    word_t            mcand;
    word_t            mplier;
    word_t            src_acc;
    word_t            src_mcand;
    word_t            src_mplier;
    word_t            acc_nx;
    logic             is_mul;
    logic             mul_done;
    logic             advance;
    word_t            ex_result;

    assign is_mul   = d_valid && d_op == ALU_MUL;
    assign mul_done = (mul_state == MUL_RUN) && (mul_cnt == '0);
    assign ex_busy  = is_mul && !mul_done;     // combinational so decode holds at once
    assign advance  = d_valid && !ex_busy;

    // one multiplier step, first step taken straight from the operands
    always_comb begin
        if (mul_state == MUL_IDLE) begin
            src_acc    = '0;
            src_mcand  = d_a;
            src_mplier = d_b;
        end else begin
            src_acc    = acc;
            src_mcand  = mcand;
            src_mplier = mplier;
        end
        acc_nx = src_acc;
        for (int i = 0; i < MUL_STEP_BITS; i++) begin
            if (src_mplier[i]) begin
                acc_nx = acc_nx + (src_mcand << i);
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (rst) begin
            mul_state <= MUL_IDLE;
        end else begin
            case (mul_state)
                MUL_IDLE: if (is_mul) mul_state <= MUL_RUN;
                MUL_RUN:  if (mul_cnt == '0) mul_state <= MUL_IDLE;
                default:  mul_state <= MUL_IDLE;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if ((mul_state == MUL_IDLE && is_mul) || (mul_state == MUL_RUN && mul_cnt != '0)) begin
            acc    <= acc_nx;
            mcand  <= src_mcand << MUL_STEP_BITS;
            mplier <= src_mplier >> MUL_STEP_BITS;
            mul_cnt <= (mul_state == MUL_IDLE) ? CNT_W'(STEPS - 1) : mul_cnt - 1'b1;
        end
    end

    always_comb begin
        case (d_op)
            ALU_ADD: ex_result = d_a + d_b;
            ALU_SUB: ex_result = d_a - d_b;
            ALU_AND: ex_result = d_a & d_b;
            ALU_OR:  ex_result = d_a | d_b;
            ALU_XOR: ex_result = d_a ^ d_b;
            ALU_SLT: ex_result = ($signed(d_a) < $signed(d_b)) ? 32'd1 : 32'd0;
            ALU_LUI: ex_result = {d_b[15:0], 16'h0};
            ALU_MUL: ex_result = acc;       // low half of the product
            default: ex_result = '0;
        endcase
    end

    // only a finished result may be forwarded
    assign ex_fwd_valid = advance && d_wr;
    assign ex_fwd_dst   = d_dst;
    assign ex_fwd_data  = ex_result;

    always_ff @(posedge aclk) begin
        if (rst) begin
            x_valid <= 1'b0;
            x_wr    <= 1'b0;
        end else begin
            x_valid <= advance;     // low while the multiplier runs
            x_wr    <= ex_fwd_valid;
        end
    end

    always_ff @(posedge aclk) begin
        if (advance) begin
            x_dst  <= d_dst;
            x_data <= ex_result;
            x_pc   <= d_pc;
        end
    end

endmodule

// File: instr_queue.sv
`timescale 1ns/1ps

module instr_queue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic        aclk,
    input  logic        rst,
    input  logic        push,
    input  logic [31:0] push_instr,
    input  logic [31:0] push_pc,
    input  logic        pop,
    output logic        head_valid,
    output logic [31:0] head_instr,
    output logic [31:0] head_pc,
    output logic        credit_return
);

    localparam int PTR_W = $clog2(QUEUE_DEPTH);
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    logic [31:0]      instr_mem [QUEUE_DEPTH];
    logic [31:0]      pc_mem    [QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             do_push;
    logic             do_pop;

    assign full       = (count == CNT_W'(QUEUE_DEPTH));
    assign head_valid = (count != '0);
    assign do_pop     = pop && head_valid;
    assign do_push    = push && (!full || do_pop);   // a slot frees on the same edge

    assign head_instr = instr_mem[rd_ptr];
    assign head_pc    = pc_mem[rd_ptr];

    always_ff @(posedge aclk) begin
        if (rst) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            credit_return <= 1'b0;
        end else begin
            credit_return <= do_pop;    // one credit back per popped entry
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (do_push) begin
            instr_mem[wr_ptr] <= push_instr;
            pc_mem[wr_ptr]    <= push_pc;
        end
    end

endmodule

// File: isa_pkg.sv
package isa_pkg;

    // architectural widths of the MIPS subset
    localparam int WORD_W   = 32;
    localparam int REG_IDX_W = 5;
    localparam int NUM_REGS = 32;
    localparam int IMM_W    = 16;

    typedef logic [WORD_W-1:0]    word_t;     // data and pc
    typedef logic [REG_IDX_W-1:0] reg_idx_t;
    typedef logic [IMM_W-1:0]     imm_t;

    // major opcode, instr[31:26]
    typedef enum logic [5:0] {
        OP_SPECIAL  = 6'h00,
        OP_ADDIU    = 6'h09,
        OP_ORI      = 6'h0d,
        OP_LUI      = 6'h0f,
        OP_SPECIAL2 = 6'h1c
    } opcode_e;

    // function field, instr[5:0]
    // MUL sits under SPECIAL2, the rest under SPECIAL
    typedef enum logic [5:0] {
        FN_MUL  = 6'h02,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_SLT  = 6'h2a
    } funct_e;

endpackage

// File: mips_slice.f
isa_pkg.sv
pipe_pkg.sv
instr_queue.sv
reg_file.sv
decode_stage.sv
execute_stage.sv
result_stage.sv
mips_slice.sv
mips_slice_props.sv
tb_mips_slice.sv

// File: mips_slice.sv
`timescale 1ns/1ps

module mips_slice import isa_pkg::*, pipe_pkg::*; #(
    parameter int QUEUE_DEPTH   = 4,    // also the source's starting credit count
    parameter int MUL_STEP_BITS = 2
) (
    input  logic       aclk,
    input  logic       rst,
    input  logic       instr_valid,
    input  word_t      instr,
    input  word_t      instr_pc,
    output logic       credit_return,
    output word_t      debug_wb_pc,
    output word_t      debug_wb_rf_wdata,
    output trace_wen_t debug_wb_rf_wen,
    output reg_idx_t   debug_wb_rf_wnum
);

    // queue head
    logic     head_valid;
    word_t    head_instr;
    word_t    head_pc;
    logic     pop;

    // register file read side
    reg_idx_t rd_idx_a;
    reg_idx_t rd_idx_b;
    word_t    rd_data_a;
    word_t    rd_data_b;

    // decode register
    logic     d_valid;
    alu_op_e  d_op;
    word_t    d_a;
    word_t    d_b;
    reg_idx_t d_dst;
    logic     d_wr;
    word_t    d_pc;

    logic     ex_busy;
    logic     ex_fwd_valid;
    reg_idx_t ex_fwd_dst;
    word_t    ex_fwd_data;

    // execute register
    logic     x_valid;
    logic     x_wr;
    reg_idx_t x_dst;
    word_t    x_data;
    word_t    x_pc;

    // write port, doubles as second bypass
    logic     wr_en;
    reg_idx_t wr_idx;
    word_t    wr_data;

    instr_queue #(
        .QUEUE_DEPTH   (QUEUE_DEPTH)
    ) u_instr_queue (
        .aclk          (aclk),
        .rst           (rst),
        .push          (instr_valid),
        .push_instr    (instr),
        .push_pc       (instr_pc),
        .pop           (pop),
        .head_valid    (head_valid),
        .head_instr    (head_instr),
        .head_pc       (head_pc),
        .credit_return (credit_return)
    );

    reg_file u_reg_file (
        .aclk          (aclk),
        .rst           (rst),
        .rd_idx_a      (rd_idx_a),
        .rd_idx_b      (rd_idx_b),
        .wr_en         (wr_en),
        .wr_idx        (wr_idx),
        .wr_data       (wr_data),
        .rd_data_a     (rd_data_a),
        .rd_data_b     (rd_data_b)
    );

    decode_stage u_decode_stage (
        .aclk          (aclk),
        .rst           (rst),
        .head_valid    (head_valid),
        .head_instr    (head_instr),
        .head_pc       (head_pc),
        .ex_busy       (ex_busy),
        .ex_fwd_valid  (ex_fwd_valid),
        .ex_fwd_dst    (ex_fwd_dst),
        .ex_fwd_data   (ex_fwd_data),
        .wr_en         (wr_en),
        .wr_idx        (wr_idx),
        .wr_data       (wr_data),
        .rd_data_a     (rd_data_a),
        .rd_data_b     (rd_data_b),
        .pop           (pop),
        .rd_idx_a      (rd_idx_a),
        .rd_idx_b      (rd_idx_b),
        .d_valid       (d_valid),
        .d_op          (d_op),
        .d_a           (d_a),
        .d_b           (d_b),
        .d_dst         (d_dst),
        .d_wr          (d_wr),
        .d_pc          (d_pc)
    );

    execute_stage #(
        .MUL_STEP_BITS (MUL_STEP_BITS)
    ) u_execute_stage (
        .aclk          (aclk),
        .rst           (rst),
        .d_valid       (d_valid),
        .d_op          (d_op),
        .d_a           (d_a),
        .d_b           (d_b),
        .d_dst         (d_dst),
        .d_wr          (d_wr),
        .d_pc          (d_pc),
        .ex_busy       (ex_busy),
        .ex_fwd_valid  (ex_fwd_valid),
        .ex_fwd_dst    (ex_fwd_dst),
        .ex_fwd_data   (ex_fwd_data),
        .x_valid       (x_valid),
        .x_wr          (x_wr),
        .x_dst         (x_dst),
        .x_data        (x_data),
        .x_pc          (x_pc)
    );

    result_stage u_result_stage (
        .aclk              (aclk),
        .rst               (rst),
        .x_valid           (x_valid),
        .x_wr              (x_wr),
        .x_dst             (x_dst),
        .x_data            (x_data),
        .x_pc              (x_pc),
        .wr_en             (wr_en),
        .wr_idx            (wr_idx),
        .wr_data           (wr_data),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wdata (debug_wb_rf_wdata),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum)
    );

endmodule

// File: mips_slice_props.sv
`timescale 1ns/1ps

module mips_slice_props import isa_pkg::*, pipe_pkg::*; (
    input logic       aclk,
    input logic       rst,
    input logic       credit_return,
    input trace_wen_t debug_wb_rf_wen,
    input reg_idx_t   debug_wb_rf_wnum
);

    // byte enables move together
    wen_whole: assert property (@(posedge aclk) disable iff (rst)
        debug_wb_rf_wen == 4'b0000 || debug_wb_rf_wen == 4'b1111)
        else $error("debug_wb_rf_wen partly set: %h", debug_wb_rf_wen);

    wnum_not_zero: assert property (@(posedge aclk) disable iff (rst)
        debug_wb_rf_wen != 4'b0000 |-> debug_wb_rf_wnum != 5'd0)
        else $error("trace reports a write to r0");

    // quiet outputs right out of reset
    quiet_after_rst: assert property (@(posedge aclk)
        rst |=> (!credit_return && debug_wb_rf_wen == 4'b0000))
        else $error("credit_return or debug_wb_rf_wen high after reset");

endmodule

bind mips_slice mips_slice_props u_mips_slice_props (
    .aclk             (aclk),
    .rst              (rst),
    .credit_return    (credit_return),
    .debug_wb_rf_wen  (debug_wb_rf_wen),
    .debug_wb_rf_wnum (debug_wb_rf_wnum)
);

// File: pipe_pkg.sv
package pipe_pkg;

    // operation carried in the decode register
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_LUI,    // imm in b, shifted up in execute
        ALU_MUL
    } alu_op_e;

    // iterative multiplier
    typedef enum logic {
        MUL_IDLE,
        MUL_RUN
    } mul_state_e;

    // golden trace byte enables
    typedef logic [3:0] trace_wen_t;

    localparam trace_wen_t WEN_ALL  = 4'b1111;
    localparam trace_wen_t WEN_NONE = 4'b0000;

endpackage

// File: reg_file.sv
`timescale 1ns/1ps

module reg_file import isa_pkg::*; (
    input  logic     aclk,
    input  logic     rst,
    input  reg_idx_t rd_idx_a,
    input  reg_idx_t rd_idx_b,
    input  logic     wr_en,
    input  reg_idx_t wr_idx,
    input  word_t    wr_data,
    output word_t    rd_data_a,
    output word_t    rd_data_b
);

    word_t regs [1:NUM_REGS-1];     // r0 has no storage

    always_ff @(posedge aclk) begin
        if (rst) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_idx != '0) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // old value on a same-cycle write, decode bypasses the new one
    assign rd_data_a = (rd_idx_a == '0) ? '0 : regs[rd_idx_a];
    assign rd_data_b = (rd_idx_b == '0) ? '0 : regs[rd_idx_b];

endmodule

// File: result_stage.sv
`timescale 1ns/1ps

module result_stage import isa_pkg::*, pipe_pkg::*; (
    input  logic       aclk,
    input  logic       rst,
    input  logic       x_valid,
    input  logic       x_wr,
    input  reg_idx_t   x_dst,
    input  word_t      x_data,
    input  word_t      x_pc,
    output logic       wr_en,
    output reg_idx_t   wr_idx,
    output word_t      wr_data,
    output word_t      debug_wb_pc,
    output word_t      debug_wb_rf_wdata,
    output trace_wen_t debug_wb_rf_wen,
    output reg_idx_t   debug_wb_rf_wnum
);

    logic trace_wr;

    // file written as the instruction enters, so decode only needs two bypasses
    assign wr_en   = x_valid && x_wr;
    assign wr_idx  = x_dst;
    assign wr_data = x_data;

    always_ff @(posedge aclk) begin
        if (rst) begin
            trace_wr <= 1'b0;
        end else begin
            trace_wr <= wr_en;
        end
    end

    // retiring instruction, kept for the golden trace
    always_ff @(posedge aclk) begin
        if (x_valid) begin
            debug_wb_pc       <= x_pc;
            debug_wb_rf_wdata <= x_data;
            debug_wb_rf_wnum  <= x_dst;
        end
    end

    assign debug_wb_rf_wen = trace_wr ? WEN_ALL : WEN_NONE;

endmodule

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_mips_slice \
    -f mips_slice.f -o sim_mips_slice &&
./obj_dir/sim_mips_slice | tee /dev/stderr | grep "RESULT: PASS" > /dev/null &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// File: tb_mips_slice.sv
`timescale 1ns/1ps

module tb_mips_slice import isa_pkg::*, pipe_pkg::*; ();

    localparam int    QUEUE_DEPTH   = 4;
    localparam int    MUL_STEP_BITS = 2;
    localparam int    SEED          = 72382;
    localparam word_t PC_BASE       = 32'hbfc0_0000;

    localparam logic [5:0] ALU_FUNCTS [6] = '{FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_SLT};

    logic       aclk = 1'b0;
    logic       rst;
    logic       instr_valid;
    word_t      instr;
    word_t      instr_pc;
    logic       credit_return;
    word_t      debug_wb_pc;
    word_t      debug_wb_rf_wdata;
    trace_wen_t debug_wb_rf_wen;
    reg_idx_t   debug_wb_rf_wnum;

    // stimulus table
    word_t    tbl_instr [$];
    word_t    tbl_pc    [$];
    bit       tbl_gap   [$];    // idle cycles may come first

    // reference registers and the writes they predict, in program order
    word_t    ref_regs [32];
    word_t    exp_pc   [$];
    word_t    exp_data [$];
    reg_idx_t exp_idx  [$];

    int value_errs  = 0;
    int other_errs  = 0;
    int writes_seen = 0;
    int n_instr     = 0;
    int credits;

    mips_slice #(
        .QUEUE_DEPTH       (QUEUE_DEPTH),
        .MUL_STEP_BITS     (MUL_STEP_BITS)
    ) i_mips_slice (
        .aclk              (aclk),
        .rst               (rst),
        .instr_valid       (instr_valid),
        .instr             (instr),
        .instr_pc          (instr_pc),
        .credit_return     (credit_return),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wdata (debug_wb_rf_wdata),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum)
    );

    always #5 aclk = ~aclk;

    function automatic word_t rtype_instr(logic [5:0] op, logic [5:0] fn, reg_idx_t rs,
                                          reg_idx_t rt, reg_idx_t rd);
        return {op, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic word_t itype_instr(logic [5:0] op, reg_idx_t rs, reg_idx_t rt, imm_t imm);
        return {op, rs, rt, imm};
    endfunction

    // adds one entry and predicts its write from the ISA rules
    task automatic append_instr(word_t ins, bit may_gap);
        word_t    a;
        word_t    b;
        word_t    val;
        reg_idx_t dst;
        bit       writes;
        a      = ref_regs[ins[25:21]];
        b      = ref_regs[ins[20:16]];
        dst    = ins[15:11];
        val    = '0;
        writes = 1'b1;
        case (ins[31:26])
            OP_SPECIAL: begin
                case (ins[5:0])
                    FN_ADDU: val = a + b;
                    FN_SUBU: val = a - b;
                    FN_AND:  val = a & b;
                    FN_OR:   val = a | b;
                    FN_XOR:  val = a ^ b;
                    FN_SLT:  val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default: writes = 1'b0;
                endcase
            end
            OP_SPECIAL2: begin
                val    = a * b;     // low half only
                writes = (ins[5:0] == FN_MUL);
            end
            OP_ADDIU: begin
                dst = ins[20:16];
                val = a + {{16{ins[15]}}, ins[15:0]};
            end
            OP_ORI: begin
                dst = ins[20:16];
                val = a | {16'h0, ins[15:0]};
            end
            OP_LUI: begin
                dst = ins[20:16];
                val = {ins[15:0], 16'h0};
            end
            default: writes = 1'b0;
        endcase
        if (writes && dst != 5'd0) begin
            ref_regs[dst] = val;
            exp_pc.push_back(PC_BASE + word_t'(4 * tbl_instr.size()));
            exp_data.push_back(val);
            exp_idx.push_back(dst);
        end
        tbl_pc.push_back(PC_BASE + word_t'(4 * tbl_instr.size()));
        tbl_instr.push_back(ins);
        tbl_gap.push_back(may_gap);
    endtask

    task automatic build_program();
        word_t    v;
        reg_idx_t rs;
        reg_idx_t rt;
        reg_idx_t rd;
        rd = 5'd1;
        // random seeds in r1..r8, ORI right behind its LUI
        for (int r = 1; r <= 8; r++) begin
            v = $urandom;
            append_instr(itype_instr(OP_LUI, 5'd0, reg_idx_t'(r), v[31:16]), 1'b1);
            append_instr(itype_instr(OP_ORI, reg_idx_t'(r), reg_idx_t'(r), v[15:0]), 1'b0);
        end
        append_instr(itype_instr(OP_ADDIU, 5'd0, 5'd9, 16'h8001), 1'b1);    // negative imm
        append_instr(itype_instr(OP_ADDIU, 5'd1, 5'd10, imm_t'($urandom)), 1'b1);
        append_instr(itype_instr(OP_ADDIU, 5'd9, 5'd11, 16'h7fff), 1'b0);
        // chain hits execute bypass, then result bypass
        append_instr(rtype_instr(OP_SPECIAL, FN_ADDU, 5'd1, 5'd2, 5'd12), 1'b1);
        append_instr(rtype_instr(OP_SPECIAL, FN_SUBU, 5'd12, 5'd3, 5'd13), 1'b0);
        append_instr(rtype_instr(OP_SPECIAL, FN_XOR, 5'd12, 5'd13, 5'd14), 1'b0);
        append_instr(rtype_instr(OP_SPECIAL, FN_SLT, 5'd14, 5'd12, 5'd15), 1'b0);
        for (int k = 0; k < 24; k++) begin
            rs = reg_idx_t'(1 + $urandom % 15);
            rt = reg_idx_t'(1 + $urandom % 15);
            rd = reg_idx_t'(1 + $urandom % 15);
            append_instr(rtype_instr(OP_SPECIAL, ALU_FUNCTS[$urandom % 6], rs, rt, rd),
                         1'($urandom % 2));
        end
        // full rate multiplies, odd ones chained on the previous product
        for (int k = 0; k < 8; k++) begin
            rs = (k % 2 == 1) ? rd : reg_idx_t'(1 + $urandom % 15);
            rt = reg_idx_t'(1 + $urandom % 15);
            rd = reg_idx_t'(16 + k);
            append_instr(rtype_instr(OP_SPECIAL2, FN_MUL, rs, rt, rd), 1'b0);
        end
        append_instr(rtype_instr(OP_SPECIAL, FN_ADDU, 5'd23, 5'd1, 5'd24), 1'b0);
        // nothing below may retire a write except the last two
        append_instr(rtype_instr(OP_SPECIAL, FN_ADDU, 5'd1, 5'd2, 5'd0), 1'b1);
        append_instr(itype_instr(OP_ADDIU, 5'd3, 5'd0, 16'h1234), 1'b0);
        append_instr(rtype_instr(OP_SPECIAL2, FN_MUL, 5'd1, 5'd2, 5'd0), 1'b0);
        append_instr(itype_instr(6'h23, 5'd1, 5'd25, 16'h0010), 1'b0);     // lw
        append_instr(rtype_instr(OP_SPECIAL, 6'h00, 5'd1, 5'd2, 5'd26), 1'b0);  // sll
        append_instr(rtype_instr(OP_SPECIAL2, 6'h00, 5'd1, 5'd2, 5'd27), 1'b0); // madd
        append_instr(rtype_instr(OP_SPECIAL, FN_OR, 5'd0, 5'd1, 5'd28), 1'b0);
        append_instr(rtype_instr(OP_SPECIAL, FN_ADDU, 5'd0, 5'd0, 5'd29), 1'b0);
    endtask

    task automatic check_word(string name, word_t got, word_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got %h, expected %h", name, got, exp);
            value_errs++;
        end
    endtask

    task automatic check_idx(string name, reg_idx_t got, reg_idx_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got %h, expected %h", name, got, exp);
            value_errs++;
        end
    endtask

    task automatic check_wen(string name, trace_wen_t got, trace_wen_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got %h, expected %h", name, got, exp);
            value_errs++;
        end
    endtask

    // one source cycle with nothing sent
    task automatic next_cycle();
        @(negedge aclk);
        if (credit_return) credits++;
        instr_valid = 1'b0;
    endtask

    // trace checker
    always @(negedge aclk) begin
        if (!rst && debug_wb_rf_wen != 4'b0000) begin
            writes_seen++;
            if (exp_pc.size() == 0) begin
                $display("write to r%0d at pc %h was not expected", debug_wb_rf_wnum,
                         debug_wb_pc);
                other_errs++;
            end else begin
                check_word("debug_wb_pc", debug_wb_pc, exp_pc.pop_front());
                check_word("debug_wb_rf_wdata", debug_wb_rf_wdata, exp_data.pop_front());
                check_idx("debug_wb_rf_wnum", debug_wb_rf_wnum, exp_idx.pop_front());
                check_wen("debug_wb_rf_wen", debug_wb_rf_wen, 4'b1111);
            end
        end
    end

    initial begin
        int idx;
        rst         = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        instr_pc    = '0;
        void'($urandom(SEED));
        for (int r = 0; r < 32; r++) ref_regs[r] = '0;
        build_program();
        credits = QUEUE_DEPTH;
        n_instr = tbl_instr.size();
        repeat (3) @(posedge aclk);
        @(negedge aclk);
        rst = 1'b0;
        // idle pipeline, nothing may come back
        repeat (4) begin
            next_cycle();
            if (credit_return) begin
                $display("credit returned before any instruction was sent");
                other_errs++;
            end
            check_wen("debug_wb_rf_wen", debug_wb_rf_wen, 4'b0000);
        end
        credits = QUEUE_DEPTH;
        idx = 0;
        while (idx < n_instr) begin
            next_cycle();
            if (credits > 0 && !(tbl_gap[idx] && $urandom % 3 == 0)) begin
                instr_valid = 1'b1;
                instr       = tbl_instr[idx];
                instr_pc    = tbl_pc[idx];
                credits--;
                idx++;
            end
        end
        // all credits home means the queue has emptied into decode
        while (credits < QUEUE_DEPTH) next_cycle();
        repeat (32 / MUL_STEP_BITS + 4) next_cycle();   // last entries retire, strays show
        if (credits != QUEUE_DEPTH) begin
            $display("source holds %0d credits after drain instead of %0d", credits, QUEUE_DEPTH);
            other_errs++;
        end
        if (exp_pc.size() != 0) begin
            $display("%0d expected writes never retired", exp_pc.size());
            other_errs++;
        end
        $display("%0d writes checked, value errors %0d, other errors %0d",
                 writes_seen, value_errs, other_errs);
        if (value_errs + other_errs == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // watchdog, sized for a worst case multiply per entry
    initial begin
        int limit;
        wait (n_instr > 0);
        limit = n_instr * (32 / MUL_STEP_BITS + 4) + 100;
        repeat (limit) @(posedge aclk);
        $display("run timed out after %0d cycles with %0d writes still expected",
                 limit, exp_pc.size());
        $display("%0d writes checked, value errors %0d, other errors %0d",
                 writes_seen, value_errs, other_errs + 1);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule
